/* list.f */
rtl/uart_host_pkg.sv
rtl/uart_reg_access.sv
rtl/tx_message_buffer.sv
rtl/uart_host_ctrl.sv
rtl/uart_host_top.sv
testbench/uart_host_props.sv
testbench/tb_uart_host.sv

/* rtl/tx_message_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module tx_message_buffer #(
  parameter uart_host_pkg::msg_t TX_MESSAGE = "Command Format\r\n"
) (
  input  logic                 clk_33M,
  input  logic                 rstn,
  input  logic                 next,
  output uart_host_pkg::byte_t tx_char
);
  import uart_host_pkg::*;

  localparam int               CNT_W     = $clog2(MSG_CHARS);
  localparam logic [CNT_W-1:0] LAST_CHAR = CNT_W'(MSG_CHARS - 1);

  msg_t             shift_q;
  logic [CNT_W-1:0] count;

  // current character is always the top byte
  assign tx_char = shift_q[MSG_CHARS*8-1 -: 8];

  always_ff @(posedge clk_33M or negedge rstn) begin
    if (!rstn) begin
      shift_q <= TX_MESSAGE;
      count   <= '0;
    end else if (next) begin
      if (count == LAST_CHAR) begin
        // wrap straight back to the first character
        shift_q <= TX_MESSAGE;
        count   <= '0;
      end else begin
        shift_q <= shift_q << 8;
        count   <= count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/uart_host_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_host_ctrl #(
  parameter logic [15:0] BAUD_DIVISOR = 16'h0011
) (
  input  logic                      clk_33M,
  input  logic                      rstn,
  output logic                      start,
  output uart_host_pkg::access_op_t op,
  output uart_host_pkg::uart_addr_t addr,
  output uart_host_pkg::byte_t      wdata,
  input  logic                      done,
  input  uart_host_pkg::byte_t      rdata,
  input  uart_host_pkg::byte_t      tx_char,
  output logic                      next,
  output uart_host_pkg::byte_t      rx_data,
  output logic                      rx_valid
);
  import uart_host_pkg::*;

  typedef enum logic [1:0] {
    ST_SETUP,
    ST_POLL,
    ST_RX,
    ST_TX
  } state_t;

  localparam logic [2:0] LAST_STEP = 3'd5;

  state_t     state;
  logic [2:0] step;
  logic       pending;
  access_op_t req_op;
  uart_addr_t req_addr;
  byte_t      req_data;
  uart_addr_t setup_addr;
  byte_t      setup_data;

  // line setup sequence
  always_comb begin
    case (step)
      3'd0: begin
        setup_addr = LCR;
        setup_data = LCR_DLAB_8N1;
      end
      3'd1: begin
        setup_addr = DLL;
        setup_data = BAUD_DIVISOR[7:0];
      end
      3'd2: begin
        setup_addr = DLM;
        setup_data = BAUD_DIVISOR[15:8];
      end
      3'd3: begin
        setup_addr = LCR;
        setup_data = LCR_8N1;
      end
      3'd4: begin
        setup_addr = FCR;
        setup_data = FCR_SETUP;
      end
      default: begin
        setup_addr = IER;
        setup_data = IER_SETUP;
      end
    endcase
  end

  // access requested by the current state
  always_comb begin
    req_op   = OP_READ;
    req_addr = LSR;
    req_data = '0;
    case (state)
      ST_SETUP: begin
        req_op   = OP_WRITE;
        req_addr = setup_addr;
        req_data = setup_data;
      end
      ST_RX: begin
        req_addr = RBR_THR;
      end
      ST_TX: begin
        req_op   = OP_WRITE;
        req_addr = RBR_THR;
        req_data = tx_char;
      end
      default: begin
        req_addr = LSR;
      end
    endcase
  end

  always_ff @(posedge clk_33M or negedge rstn) begin
    if (!rstn) begin
      state    <= ST_SETUP;
      step     <= '0;
      pending  <= 1'b0;
      start    <= 1'b0;
      next     <= 1'b0;
      rx_valid <= 1'b0;
    end else begin
      start    <= 1'b0;
      next     <= 1'b0;
      rx_valid <= 1'b0;
      if (!pending) begin
        start   <= 1'b1;
        pending <= 1'b1;
      end else if (done) begin
        pending <= 1'b0;
        case (state)
          ST_SETUP: begin
            if (step == LAST_STEP) begin
              state <= ST_POLL;
            end else begin
              step <= step + 1'b1;
            end
          end
          ST_POLL: begin
            // received data wins over a free transmitter
            if (rdata[LSR_DR_BIT]) begin
              state <= ST_RX;
            end else if (rdata[LSR_THRE_BIT]) begin
              state <= ST_TX;
            end
          end
          ST_RX: begin
            rx_valid <= 1'b1;
            state    <= ST_POLL;
          end
          default: begin
            next  <= 1'b1;
            state <= ST_POLL;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk_33M) begin
    if (!pending) begin
      op    <= req_op;
      addr  <= req_addr;
      wdata <= req_data;
    end
    if (pending && done && state == ST_RX) begin
      rx_data <= rdata;
    end
  end

endmodule

`default_nettype wire

/* rtl/uart_host_pkg.sv */
`default_nettype none

package uart_host_pkg;

  typedef logic [7:0] byte_t;

  // 16750 register address decoded inside the UART
  typedef logic [2:0] uart_addr_t;

  localparam uart_addr_t RBR_THR = 3'd0;
  localparam uart_addr_t IER     = 3'd1;
  localparam uart_addr_t FCR     = 3'd2;
  localparam uart_addr_t LCR     = 3'd3;
  localparam uart_addr_t MCR     = 3'd4;
  localparam uart_addr_t LSR     = 3'd5;
  localparam uart_addr_t MSR     = 3'd6;
  localparam uart_addr_t SCR     = 3'd7;

  // divisor latch aliases valid while LCR.DLAB is set
  localparam uart_addr_t DLL = 3'd0;
  localparam uart_addr_t DLM = 3'd1;

  // request side of the UART register bus
  typedef struct packed {
    logic       cs;
    logic       wr;
    logic       rd;
    uart_addr_t addr;
    byte_t      wdata;
  } uart_bus_t;

  // line setup values
  localparam byte_t LCR_DLAB_8N1 = 8'h83;
  localparam byte_t LCR_8N1      = 8'h03;
  localparam byte_t FCR_SETUP    = 8'h00;
  localparam byte_t IER_SETUP    = 8'h03;

  localparam int unsigned LSR_DR_BIT   = 0;
  localparam int unsigned LSR_THRE_BIT = 5;

  // first character sits in the top byte
  localparam int unsigned MSG_CHARS = 16;
  typedef logic [MSG_CHARS*8-1:0] msg_t;

  typedef enum logic {
    OP_WRITE = 1'b0,
    OP_READ  = 1'b1
  } access_op_t;

endpackage

`default_nettype wire

/* rtl/uart_host_top.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_host_top #(
  parameter logic [15:0]         BAUD_DIVISOR = 16'h0011,
  parameter uart_host_pkg::msg_t TX_MESSAGE   = "Command Format\r\n"
) (
  input  logic                     clk_33M,
  input  logic                     rstn,
  output uart_host_pkg::uart_bus_t uart_bus,
  input  uart_host_pkg::byte_t     bus_rdata,
  output uart_host_pkg::byte_t     rx_data,
  output logic                     rx_valid
);
  import uart_host_pkg::*;

  logic       start;
  logic       done;
  logic       next;
  access_op_t op;
  uart_addr_t addr;
  byte_t      wdata;
  byte_t      rdata;
  byte_t      tx_char;

  uart_host_ctrl #(
    .BAUD_DIVISOR(BAUD_DIVISOR)
  ) uart_host_ctrl_inst (
    .clk_33M (clk_33M),
    .rstn    (rstn),
    .start   (start),
    .op      (op),
    .addr    (addr),
    .wdata   (wdata),
    .done    (done),
    .rdata   (rdata),
    .tx_char (tx_char),
    .next    (next),
    .rx_data (rx_data),
    .rx_valid(rx_valid)
  );

  uart_reg_access uart_reg_access_inst (
    .clk_33M  (clk_33M),
    .rstn     (rstn),
    .start    (start),
    .op       (op),
    .addr     (addr),
    .wdata    (wdata),
    .bus      (uart_bus),
    .bus_rdata(bus_rdata),
    .done     (done),
    .rdata    (rdata)
  );

  tx_message_buffer #(
    .TX_MESSAGE(TX_MESSAGE)
  ) tx_message_buffer_inst (
    .clk_33M(clk_33M),
    .rstn   (rstn),
    .next   (next),
    .tx_char(tx_char)
  );

endmodule

`default_nettype wire

/* rtl/uart_reg_access.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_reg_access (
  input  logic                      clk_33M,
  input  logic                      rstn,
  input  logic                      start,
  input  uart_host_pkg::access_op_t op,
  input  uart_host_pkg::uart_addr_t addr,
  input  uart_host_pkg::byte_t      wdata,
  output uart_host_pkg::uart_bus_t  bus,
  input  uart_host_pkg::byte_t      bus_rdata,
  output logic                      done,
  output uart_host_pkg::byte_t      rdata
);
  import uart_host_pkg::*;

  localparam logic [1:0] PH_IDLE   = 2'd0;
  localparam logic [1:0] PH_FIRST  = 2'd1;
  localparam logic [1:0] PH_SECOND = 2'd2;
  localparam logic [1:0] PH_THIRD  = 2'd3;

  logic [1:0] phase;
  logic       cs_q;
  logic       wr_q;
  logic       rd_q;
  access_op_t op_q;
  uart_addr_t addr_q;
  byte_t      wdata_q;

  always_comb begin
    bus.cs    = cs_q;
    bus.wr    = wr_q;
    bus.rd    = rd_q;
    bus.addr  = addr_q;
    bus.wdata = wdata_q;
  end

  // a write holds cs for 2 cycles and a read for 3
  always_ff @(posedge clk_33M or negedge rstn) begin
    if (!rstn) begin
      phase <= PH_IDLE;
      cs_q  <= 1'b0;
      wr_q  <= 1'b0;
      rd_q  <= 1'b0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (phase)
        PH_IDLE: begin
          if (start) begin
            cs_q  <= 1'b1;
            phase <= PH_FIRST;
          end
        end
        PH_FIRST: begin
          if (op_q == OP_WRITE) begin
            wr_q <= 1'b1;
          end else begin
            rd_q <= 1'b1;
          end
          phase <= PH_SECOND;
        end
        PH_SECOND: begin
          if (op_q == OP_WRITE) begin
            cs_q  <= 1'b0;
            wr_q  <= 1'b0;
            done  <= 1'b1;
            phase <= PH_IDLE;
          end else begin
            phase <= PH_THIRD;
          end
        end
        default: begin
          cs_q  <= 1'b0;
          rd_q  <= 1'b0;
          done  <= 1'b1;
          phase <= PH_IDLE;
        end
      endcase
    end
  end

  // request latched at start and read byte taken in the last rd cycle
  always_ff @(posedge clk_33M) begin
    if (phase == PH_IDLE && start) begin
      op_q    <= op;
      addr_q  <= addr;
      wdata_q <= wdata;
    end
    if (phase == PH_THIRD) begin
      rdata <= bus_rdata;
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# builds and runs the UART host testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_uart_host \
  -f list.f -o sim_uart_host
./obj_dir/sim_uart_host 2>&1 | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"

/* testbench/tb_uart_host.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_uart_host;
  import uart_host_pkg::*;

  localparam logic [15:0] TB_DIVISOR   = 16'h0A11;
  localparam msg_t        TB_MESSAGE   = "Hello UART host\n";
  localparam int unsigned TX_GOAL      = 2 * MSG_CHARS + 4;
  localparam int unsigned MAX_ACCESSES = 2000;
  localparam int unsigned WAIT_LIMIT   = 50;
  localparam int unsigned RUN_LIMIT    = 40000;

  typedef struct packed {
    access_op_t op;
    uart_addr_t addr;
    byte_t      data;
  } access_t;

  // one finished access plus the receive outputs a cycle later
  typedef struct {
    access_t     acc;
    logic        rx_after;
    byte_t       rx_byte;
    int unsigned rx_total;
  } access_rec_t;

  logic        clk_33M;
  logic        rstn;
  uart_bus_t   uart_bus;
  byte_t       bus_rdata;
  byte_t       rx_data;
  logic        rx_valid;

  access_rec_t rec_q[$];
  access_rec_t done_rec;
  access_t     cur;
  logic        cs_prev;
  logic        answered;
  logic        have_rec;
  int unsigned rx_pulses;
  logic [15:0] lfsr;
  int unsigned value_errors;
  int unsigned timeout_count;
  int unsigned checked_count;
  logic        checks_done;

  uart_host_top #(
    .BAUD_DIVISOR(TB_DIVISOR),
    .TX_MESSAGE  (TB_MESSAGE)
  ) uart_host_top_inst (
    .clk_33M  (clk_33M),
    .rstn     (rstn),
    .uart_bus (uart_bus),
    .bus_rdata(bus_rdata),
    .rx_data  (rx_data),
    .rx_valid (rx_valid)
  );

  always #10 clk_33M = ~clk_33M;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int unsigned n, output byte_t bits);
    int unsigned i;
    bits = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      bits = {bits[6:0], lfsr[0]};
    end
  endtask

  // LSR gives random DR and THRE bits and RBR a random byte
  task automatic model_read(input uart_addr_t a, output byte_t value);
    byte_t bits;
    value = '0;
    if (a == LSR) begin
      take_bits(2, bits);
      value[0] = bits[1];
      value[5] = bits[0];
    end else if (a == RBR_THR) begin
      take_bits(8, value);
    end
  endtask

  function automatic byte_t message_char(input int unsigned idx);
    return TB_MESSAGE[(MSG_CHARS - 1 - idx) * 8 +: 8];
  endfunction

  // expected access from its position, the access before it and the message position
  function automatic access_t expected_access(input int unsigned index, input access_t prev,
                                              input int unsigned char_idx);
    access_t e;
    e = '{OP_READ, LSR, 8'h00};
    case (index)
      0: e = '{OP_WRITE, LCR, 8'h83};
      1: e = '{OP_WRITE, DLL, TB_DIVISOR[7:0]};
      2: e = '{OP_WRITE, DLM, TB_DIVISOR[15:8]};
      3: e = '{OP_WRITE, LCR, 8'h03};
      4: e = '{OP_WRITE, FCR, 8'h00};
      5: e = '{OP_WRITE, IER, 8'h03};
      default: begin
        if (prev.op == OP_READ && prev.addr == LSR) begin
          if (prev.data[0]) begin
            e = '{OP_READ, RBR_THR, 8'h00};
          end else if (prev.data[5]) begin
            e = '{OP_WRITE, RBR_THR, message_char(char_idx)};
          end
        end
      end
    endcase
    return e;
  endfunction

  task automatic check_op(input string what, input access_op_t got, input access_op_t exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", what, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_addr(input string what, input uart_addr_t got, input uart_addr_t exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", what, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_byte(input string what, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", what, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_valid(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", what, got, exp);
      value_errors++;
    end
  endtask

  // register model and bus monitor
  always @(negedge clk_33M) begin : register_model
    byte_t reply;
    if (!rstn) begin
      cs_prev   = 1'b0;
      answered  = 1'b0;
      have_rec  = 1'b0;
      rx_pulses = 0;
      lfsr      = 16'd58;
    end else begin
      if (rx_valid) begin
        rx_pulses++;
      end
      if (have_rec) begin
        done_rec.rx_after = rx_valid;
        done_rec.rx_byte  = rx_data;
        done_rec.rx_total = rx_pulses;
        rec_q.push_back(done_rec);
        have_rec = 1'b0;
      end
      if (uart_bus.cs && !cs_prev) begin
        cur      = '{OP_READ, uart_bus.addr, uart_bus.wdata};
        answered = 1'b0;
      end
      if (uart_bus.cs && uart_bus.wr) begin
        cur.op = OP_WRITE;
      end
      if (uart_bus.cs && uart_bus.rd) begin
        if (!answered) begin
          // read data is valid in the last rd cycle only
          model_read(uart_bus.addr, reply);
          bus_rdata = ~reply;
          cur.data  = reply;
          answered  = 1'b1;
        end else begin
          bus_rdata = cur.data;
        end
      end
      if (!uart_bus.cs && cs_prev) begin
        done_rec.acc = cur;
        have_rec     = 1'b1;
      end
      cs_prev = uart_bus.cs;
    end
  end

  initial begin : compare_process
    access_rec_t rec;
    access_t     prev;
    access_t     exp;
    int unsigned char_idx;
    int unsigned rx_reads;
    int unsigned tx_writes;
    int unsigned idle_polls;
    int unsigned wait_cycles;
    logic        is_rx;
    logic        abort;
    char_idx    = 0;
    rx_reads    = 0;
    tx_writes   = 0;
    idle_polls  = 0;
    abort       = 1'b0;
    prev        = '0;
    wait_cycles = 0;
    while (rstn !== 1'b1 && wait_cycles < 2 * WAIT_LIMIT) begin
      @(posedge clk_33M);
      wait_cycles++;
    end
    if (rstn !== 1'b1) begin
      $display("ERROR: reset was never released");
      timeout_count++;
      abort = 1'b1;
    end
    while (!abort && !(tx_writes >= TX_GOAL && rx_reads >= 4 && idle_polls >= 4)) begin
      wait_cycles = 0;
      while (rec_q.size() == 0 && wait_cycles < WAIT_LIMIT) begin
        @(posedge clk_33M);
        wait_cycles++;
      end
      if (rec_q.size() == 0) begin
        $display("ERROR: no bus access finished within %0d cycles after access %0d",
                 WAIT_LIMIT, checked_count);
        timeout_count++;
        abort = 1'b1;
      end else if (checked_count >= MAX_ACCESSES) begin
        $display("ERROR: receive, transmit and idle cases not all seen in %0d accesses",
                 MAX_ACCESSES);
        timeout_count++;
        abort = 1'b1;
      end else begin
        rec = rec_q.pop_front();
        exp = expected_access(checked_count, prev, char_idx);
        check_op($sformatf("uart_bus op of access %0d", checked_count), rec.acc.op, exp.op);
        check_addr($sformatf("uart_bus.addr of access %0d", checked_count),
                   rec.acc.addr, exp.addr);
        if (exp.op == OP_WRITE) begin
          check_byte($sformatf("uart_bus.wdata of access %0d", checked_count),
                     rec.acc.data, exp.data);
        end
        is_rx = checked_count >= 6 && exp.op == OP_READ && exp.addr == RBR_THR;
        if (is_rx) begin
          rx_reads++;
          check_byte("rx_data", rec.rx_byte, rec.acc.data);
        end
        check_valid($sformatf("rx_valid after access %0d", checked_count), rec.rx_after, is_rx);
        if (rec.rx_total != rx_reads) begin
          $display("ERROR: rx_valid high for %0d cycles after %0d receive reads",
                   rec.rx_total, rx_reads);
          value_errors++;
        end
        if (checked_count >= 6 && exp.op == OP_WRITE) begin
          tx_writes++;
          char_idx = (char_idx + 1) % MSG_CHARS;
        end
        if (checked_count >= 6 && prev.op == OP_READ && prev.addr == LSR &&
            !prev.data[0] && !prev.data[5]) begin
          idle_polls++;
        end
        prev = rec.acc;
        checked_count++;
      end
    end
    checks_done = 1'b1;
  end

  initial begin : stimulus
    int unsigned wait_cycles;
    clk_33M       = 1'b0;
    rstn          = 1'b0;
    bus_rdata     = '0;
    value_errors  = 0;
    timeout_count = 0;
    checked_count = 0;
    checks_done   = 1'b0;
    repeat (10) @(negedge clk_33M);
    rstn = 1'b1;
    wait_cycles = 0;
    while (!checks_done && wait_cycles < RUN_LIMIT) begin
      @(negedge clk_33M);
      wait_cycles++;
    end
    if (!checks_done) begin
      $display("ERROR: access checks did not finish within %0d cycles", RUN_LIMIT);
      timeout_count++;
    end
    $display("errors: %0d wrong values, %0d timeouts, %0d accesses checked",
             value_errors, timeout_count, checked_count);
    if (value_errors == 0 && timeout_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/uart_host_props.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_host_props (
  input logic                     clk_33M,
  input logic                     rstn,
  input uart_host_pkg::uart_bus_t bus,
  input logic                     done
);

  // first cs cycle is address setup only
  a_quiet_first: assert property (@(posedge clk_33M) disable iff (!rstn)
    $rose(bus.cs) |-> !bus.wr && !bus.rd)
    else $error("wr or rd high in the first cs cycle");

  a_one_strobe: assert property (@(posedge clk_33M) disable iff (!rstn)
    $rose(bus.cs) |=> bus.cs && (bus.wr != bus.rd))
    else $error("second cs cycle without exactly one strobe");

  a_write_last: assert property (@(posedge clk_33M) disable iff (!rstn)
    bus.wr |=> !bus.cs && !bus.wr)
    else $error("write cycle longer than two cs cycles");

  a_read_two: assert property (@(posedge clk_33M) disable iff (!rstn)
    $rose(bus.rd) |=> bus.rd && bus.cs)
    else $error("rd dropped after one cycle");

  a_read_last: assert property (@(posedge clk_33M) disable iff (!rstn)
    bus.rd && $past(bus.rd) |=> !bus.cs && !bus.rd)
    else $error("read cycle longer than three cs cycles");

  a_addr_stable: assert property (@(posedge clk_33M) disable iff (!rstn)
    bus.cs && $past(bus.cs) |-> $stable(bus.addr) && $stable(bus.wdata))
    else $error("addr or wdata changed while cs high");

  // done lands in the first idle cycle
  a_done_after_cs: assert property (@(posedge clk_33M) disable iff (!rstn)
    $fell(bus.cs) |-> done)
    else $error("done missing after cs fell");

endmodule

bind uart_reg_access uart_host_props uart_host_props_inst (
  .clk_33M(clk_33M),
  .rstn   (rstn),
  .bus    (bus),
  .done   (done)
);

`default_nettype wire
